//--- controlUnit.sv
/* Instruction control unit top level. Takes one control word per
   rising edge and drives datapath controls and memory addresses. */

`timescale 1ns/1ps

module controlUnit
  import isaPkg::*, ctrlPkg::*;
(
  input  logic CLK,
  input  logic rstN,
  input  instr_t controlWord,
  input  aluStatus_t aluStatus,
  input  ptrRegs_t ptrRegs,
  output dpCtrl_t dpCtrl,
  output word_t dout,
  output memAddrs_t memAddrs,
  output word_t progRomAdd
);

  addrLoad_t addrLoad;
  flowCtl_t flowCtl;

  instrDecoder decoder (
    .CLK(CLK),
    .rstN(rstN),
    .instr(controlWord),
    .dpCtrl(dpCtrl),
    .dout(dout),
    .addrLoad(addrLoad),
    .flowCtl(flowCtl)
  );

  memAddrRegs addrRegs (
    .CLK(CLK),
    .rstN(rstN),
    .addrLoad(addrLoad),
    .imm(controlWord.imm),
    .ptrRegs(ptrRegs),
    .memAddrs(memAddrs)
  );

  // immediate doubles as the branch target
  pcSequencer sequencer (
    .CLK(CLK),
    .rstN(rstN),
    .flowCtl(flowCtl),
    .target(controlWord.imm),
    .aluStatus(aluStatus),
    .pc(progRomAdd)
  );

endmodule

//--- ctrlPkg.sv
/* Control-side types: datapath strobes, address register loads and
   program flow requests passed between the decoder and sequencers. */

package ctrlPkg;

  import isaPkg::*;

  typedef enum logic [2:0] {
    busIdle,
    busRegOut,
    busRam,
    busDataRom,
    busGpu,
    busImm
  } busSrc_e;

  typedef enum logic [3:0] {
    aluNone,
    aluPass,
    aluCmp,
    aluAdd,
    aluSub,
    aluMul,
    aluAnd,
    aluOr,
    aluXor,
    aluNot,
    aluLsl,
    aluLsr
  } aluFunc_e;

  typedef struct packed {
    busSrc_e busSrc;
    aluFunc_e aluFunc;
    logic aluReadBus;
    logic ramWrite;
    logic gpuWrite;
    regSel_t srcA;
    regSel_t srcB;
    regSel_t dest;
  } dpCtrl_t;

  // datapath at rest and just after reset
  localparam dpCtrl_t dpIdle = '{
    busSrc: busIdle,
    aluFunc: aluNone,
    aluReadBus: 1'b0,
    ramWrite: 1'b0,
    gpuWrite: 1'b0,
    srcA: '0,
    srcB: '0,
    dest: '0
  };

  typedef enum logic [1:0] {atNone, atRam, atDataRom, atGpu} addrTarget_e;

  typedef struct packed {
    addrTarget_e target;
    logic fromPtr;
  } addrLoad_t;

  typedef enum logic [1:0] {flowNext, flowJump, flowCall, flowReturn} flowOp_e;

  typedef struct packed {
    flowOp_e op;
    logic conditional;
    condMask_t mask;
  } flowCtl_t;

  typedef struct packed {
    word_t f;
    word_t g;
    word_t h;
  } ptrRegs_t;

  typedef struct packed {
    word_t ram;
    word_t dataRom;
    word_t gpu;
  } memAddrs_t;

endpackage

//--- ctrlUnit_cfg.svh
/* Sizes and reset values for the instruction control unit.
   Included by the packages and by modules that size storage. */

`ifndef CTRL_UNIT_CFG_SVH
`define CTRL_UNIT_CFG_SVH

// data bus and every address register
`define WORD_W 16

// register file select
`define REG_SEL_W 3

// ALU status flags and the width of a branch condition mask
`define STATUS_W 6

// return-address stack entries
`define STACK_DEPTH 16

// RAM window starts above the low region
`define RAM_ADDR_RESET 1024

`endif

//--- filelist.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
memAddrRegs.sv
returnStack.sv
pcSequencer.sv
controlUnit.sv
tbControlUnit.sv

//--- instrDecoder.sv
/* Decodes one control word per cycle. Datapath controls and dout are
   registered; address-load and flow requests leave combinationally. */

`timescale 1ns/1ps

module instrDecoder
  import isaPkg::*, ctrlPkg::*;
(
  input  logic CLK,
  input  logic rstN,
  input  instr_t instr,
  output dpCtrl_t dpCtrl,
  output word_t dout,
  output addrLoad_t addrLoad,
  output flowCtl_t flowCtl
);

  dpCtrl_t nextCtrl;
  logic doutLoad;

  always_comb
  begin
    nextCtrl = dpIdle;
    doutLoad = 1'b0;
    addrLoad = '{target: atNone, fromPtr: 1'b0};
    flowCtl = '{op: flowNext, conditional: 1'b0, mask: '0};

    case (instr.opcode)
      // LPT is LDR with the pointer register as address source
      opLdr, opLpt:
      begin
        nextCtrl.dest = instr.results;
        nextCtrl.aluFunc = aluPass;
        nextCtrl.aluReadBus = 1'b1;
        addrLoad.fromPtr = (instr.opcode == opLpt);
        case (instr.opvar)
          2'd0:
          begin
            nextCtrl.busSrc = busRam;
            addrLoad.target = atRam;
          end
          2'd1:
          begin
            nextCtrl.busSrc = busDataRom;
            addrLoad.target = atDataRom;
          end
          2'd2:
          begin
            nextCtrl.busSrc = busGpu;
            addrLoad.target = atGpu;
          end
          default:
          begin
            // LPT has nothing to drive in the immediate form
            nextCtrl.busSrc = (instr.opcode == opLdr) ? busImm : busIdle;
            doutLoad = (instr.opcode == opLdr);
          end
        endcase
      end
      opStr:
      begin
        nextCtrl.busSrc = busRegOut;
        nextCtrl.srcA = instr.operand1;
        if (instr.opvar == 2'd0)
        begin
          addrLoad.target = atRam;
          nextCtrl.ramWrite = 1'b1;
        end
        else if (instr.opvar == 2'd2)
        begin
          addrLoad.target = atGpu;
          nextCtrl.gpuWrite = 1'b1;
        end
      end
      opSpt:
      begin
        nextCtrl.srcA = instr.operand1;
        addrLoad.fromPtr = 1'b1;
        addrLoad.target = instr.opvar[0] ? atGpu : atRam;
        nextCtrl.ramWrite = !instr.opvar[0];
        nextCtrl.gpuWrite = instr.opvar[0];
        // high bit stores the immediate instead of a register
        nextCtrl.busSrc = instr.opvar[1] ? busImm : busRegOut;
        doutLoad = instr.opvar[1];
      end
      opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot, opLsl, opLsr:
      begin
        nextCtrl.srcA = instr.operand1;
        // compare only sets status and writes no register
        nextCtrl.dest = (instr.opcode == opCmp) ? regSel_t'(0) : instr.results;
        case (instr.opcode)
          opCmp: nextCtrl.aluFunc = aluCmp;
          opAdd: nextCtrl.aluFunc = aluAdd;
          opSub: nextCtrl.aluFunc = aluSub;
          opMul: nextCtrl.aluFunc = aluMul;
          opAnd: nextCtrl.aluFunc = aluAnd;
          opOr: nextCtrl.aluFunc = aluOr;
          opXor: nextCtrl.aluFunc = aluXor;
          opNot: nextCtrl.aluFunc = aluNot;
          opLsl: nextCtrl.aluFunc = aluLsl;
          default: nextCtrl.aluFunc = aluLsr;
        endcase
        case (instr.opvar)
          2'd0:
          begin
            nextCtrl.busSrc = busRam;
            nextCtrl.aluReadBus = 1'b1;
            addrLoad.target = atRam;
          end
          2'd1:
          begin
            // register-register form
            nextCtrl.srcB = instr.operand2;
          end
          2'd2:
          begin
            nextCtrl.busSrc = busGpu;
            nextCtrl.aluReadBus = 1'b1;
            addrLoad.target = atGpu;
          end
          default:
          begin
            nextCtrl.busSrc = busImm;
            nextCtrl.aluReadBus = 1'b1;
            doutLoad = 1'b1;
          end
        endcase
      end
      opJmp, opJoc:
        flowCtl.op = flowJump;
      opJsr, opJsc:
        flowCtl.op = flowCall;
      opRts, opRsc:
        flowCtl.op = flowReturn;
      default:
      begin
        // NOP, DIV, MOD and unassigned codes stay idle
      end
    endcase

    // conditional branches carry their mask in the operand fields
    if (instr.opcode inside {opJoc, opJsc, opRsc})
    begin
      flowCtl.conditional = 1'b1;
      flowCtl.mask = {instr.operand2, instr.operand1};
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rstN)
    begin
      dpCtrl <= dpIdle;
      dout <= '0;
    end
    else
    begin
      dpCtrl <= nextCtrl;
      if (doutLoad)
        dout <= instr.imm;
    end
  end

endmodule

//--- isaPkg.sv
/* Instruction set view of the control word: field layout, opcodes
   and the status and condition types used by branches. */

`include "ctrlUnit_cfg.svh"

package isaPkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_SEL_W-1:0] regSel_t;

  typedef logic [`STATUS_W-1:0] aluStatus_t;
  typedef logic [`STATUS_W-1:0] condMask_t;

  // 0x09 and 0x0A are reserved and decode as NOP
  typedef enum logic [4:0] {
    opNop = 5'h00,
    opLdr = 5'h01,
    opStr = 5'h02,
    opLpt = 5'h03,
    opSpt = 5'h04,
    opCmp = 5'h05,
    opAdd = 5'h06,
    opSub = 5'h07,
    opMul = 5'h08,
    opDiv = 5'h09,
    opMod = 5'h0A,
    opAnd = 5'h0B,
    opOr  = 5'h0C,
    opXor = 5'h0D,
    opNot = 5'h0E,
    opLsl = 5'h0F,
    opLsr = 5'h10,
    opJmp = 5'h14,
    opJsr = 5'h15,
    opRts = 5'h16,
    opJoc = 5'h17,
    opJsc = 5'h18,
    opRsc = 5'h19
  } opcode_e;

  // upper half is the immediate, lower half the register fields
  typedef struct packed {
    word_t imm;
    regSel_t results;
    regSel_t operand2;
    regSel_t operand1;
    opcode_e opcode;
    logic [1:0] opvar;
  } instr_t;

endpackage

//--- memAddrRegs.sv
/* RAM, data ROM and GPU address registers. One register per cycle may
   load, from the immediate or from its matching pointer register. */

`timescale 1ns/1ps
`include "ctrlUnit_cfg.svh"

module memAddrRegs
  import isaPkg::*, ctrlPkg::*;
(
  input  logic CLK,
  input  logic rstN,
  input  addrLoad_t addrLoad,
  input  word_t imm,
  input  ptrRegs_t ptrRegs,
  output memAddrs_t memAddrs
);

  always_ff @(posedge CLK)
  begin
    if (!rstN)
    begin
      memAddrs.ram <= word_t'(`RAM_ADDR_RESET);
      memAddrs.dataRom <= '0;
      memAddrs.gpu <= '0;
    end
    else
    begin
      // f, g and h pair with RAM, data ROM and GPU
      case (addrLoad.target)
        atRam:
          memAddrs.ram <= addrLoad.fromPtr ? ptrRegs.f : imm;
        atDataRom:
          memAddrs.dataRom <= addrLoad.fromPtr ? ptrRegs.g : imm;
        atGpu:
          memAddrs.gpu <= addrLoad.fromPtr ? ptrRegs.h : imm;
        default:
        begin
          // hold all three
        end
      endcase
    end
  end

endmodule

//--- pcSequencer.sv
/* Program counter. Resolves branch conditions against the ALU status
   and steps, jumps, calls or returns through the return stack. */

`timescale 1ns/1ps

module pcSequencer
  import isaPkg::*, ctrlPkg::*;
(
  input  logic CLK,
  input  logic rstN,
  input  flowCtl_t flowCtl,
  input  word_t target,
  input  aluStatus_t aluStatus,
  output word_t pc
);

  logic condMet;
  flowOp_e effOp;
  word_t pcPlus1;
  word_t stackTop;
  logic push;
  logic pop;

  // any selected flag set takes the branch
  assign condMet = |(flowCtl.mask & aluStatus);

  always_comb
  begin
    effOp = flowCtl.op;
    if (flowCtl.conditional && !condMet)
      effOp = flowNext;
  end

  assign pcPlus1 = pc + 1'b1;
  assign push = (effOp == flowCall);
  assign pop = (effOp == flowReturn);

  returnStack stack (
    .CLK(CLK),
    .rstN(rstN),
    .push(push),
    .pop(pop),
    .pushData(pcPlus1),
    .top(stackTop)
  );

  always_ff @(posedge CLK)
  begin
    if (!rstN)
      pc <= '0;
    else
    begin
      case (effOp)
        flowJump, flowCall: pc <= target;
        flowReturn: pc <= stackTop;
        default: pc <= pcPlus1;
      endcase
    end
  end

endmodule

//--- returnStack.sv
/* Subroutine return-address stack. The pointer wraps at both ends,
   so overflow silently overwrites the oldest entries. */

`timescale 1ns/1ps
`include "ctrlUnit_cfg.svh"

module returnStack
  import isaPkg::*;
(
  input  logic CLK,
  input  logic rstN,
  input  logic push,
  input  logic pop,
  input  word_t pushData,
  output word_t top
);

  localparam int PtrW = $clog2(`STACK_DEPTH);

  word_t mem [`STACK_DEPTH];
  logic [PtrW-1:0] ptr;
  logic [PtrW-1:0] ptrInc;
  logic [PtrW-1:0] ptrDec;

  assign ptrInc = (ptr == PtrW'(`STACK_DEPTH - 1)) ? '0 : ptr + 1'b1;
  assign ptrDec = (ptr == '0) ? PtrW'(`STACK_DEPTH - 1) : ptr - 1'b1;

  // pointer sits one past the newest entry
  assign top = mem[ptrDec];

  always_ff @(posedge CLK)
  begin
    if (push)
      mem[ptr] <= pushData;
  end

  always_ff @(posedge CLK)
  begin
    if (!rstN)
      ptr <= '0;
    else if (push)
      ptr <= ptrInc;
    else if (pop)
      ptr <= ptrDec;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbControlUnit -f filelist.f -o simControlUnit
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/simControlUnit
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- tbControlUnit.sv
/* Self-checking testbench for the control unit. Random control words go in
   on falling edges and a reference model predicts every registered output. */

`timescale 1ns/1ps
`include "ctrlUnit_cfg.svh"

module tbControlUnit
  import isaPkg::*, ctrlPkg::*;
();

  // reset, load/store, ALU, call/return, conditional, idle codes, random mix
  localparam int TestCycles = 3 + 128 + 160 + 36 + 200 + 112 + 300;
  localparam int CycleLimit = TestCycles + 100;

  logic CLK = 1'b1;
  logic rstN;
  instr_t controlWord;
  aluStatus_t aluStatus;
  ptrRegs_t ptrRegs;
  dpCtrl_t dpCtrl;
  word_t dout;
  memAddrs_t memAddrs;
  word_t progRomAdd;

  // model state as it should look just after the next rising edge
  dpCtrl_t expCtrl;
  memAddrs_t expAddrs;
  word_t expDout;
  word_t expPc;
  word_t stackModel [`STACK_DEPTH];
  int sp;
  string testName;
  int cycles;
  int condTaken;
  int condSkipped;

  controlUnit dut (
    .CLK(CLK),
    .rstN(rstN),
    .controlWord(controlWord),
    .aluStatus(aluStatus),
    .ptrRegs(ptrRegs),
    .dpCtrl(dpCtrl),
    .dout(dout),
    .memAddrs(memAddrs),
    .progRomAdd(progRomAdd)
  );

  always #20 CLK = ~CLK;

  function automatic dpCtrl_t idleCtrl();
    dpCtrl_t c;
    c.busSrc = busIdle;
    c.aluFunc = aluNone;
    c.aluReadBus = 1'b0;
    c.ramWrite = 1'b0;
    c.gpuWrite = 1'b0;
    c.srcA = 3'd0;
    c.srcB = 3'd0;
    c.dest = 3'd0;
    return c;
  endfunction

  function automatic aluFunc_e expectedAlu(opcode_e op);
    case (op)
      opCmp: return aluCmp;
      opAdd: return aluAdd;
      opSub: return aluSub;
      opMul: return aluMul;
      opAnd: return aluAnd;
      opOr: return aluOr;
      opXor: return aluXor;
      opNot: return aluNot;
      opLsl: return aluLsl;
      opLsr: return aluLsr;
      default: return aluNone;
    endcase
  endfunction

  // advances the reference model by one rising edge
  function automatic void modelStep(logic rst, instr_t w, aluStatus_t st, ptrRegs_t p);
    dpCtrl_t c;
    int flow;
    c = idleCtrl();
    flow = 0;
    if (!rst)
    begin
      expAddrs.ram = word_t'(`RAM_ADDR_RESET);
      expAddrs.dataRom = 16'h0;
      expAddrs.gpu = 16'h0;
      expDout = 16'h0;
      expPc = 16'h0;
      sp = 0;
    end
    else
    begin
      case (w.opcode)
        opLdr, opLpt:
        begin
          c.dest = w.results;
          c.aluFunc = aluPass;
          c.aluReadBus = 1'b1;
          case (w.opvar)
            2'd0:
            begin
              c.busSrc = busRam;
              expAddrs.ram = (w.opcode == opLpt) ? p.f : w.imm;
            end
            2'd1:
            begin
              c.busSrc = busDataRom;
              expAddrs.dataRom = (w.opcode == opLpt) ? p.g : w.imm;
            end
            2'd2:
            begin
              c.busSrc = busGpu;
              expAddrs.gpu = (w.opcode == opLpt) ? p.h : w.imm;
            end
            default:
            begin
              if (w.opcode == opLdr)
              begin
                c.busSrc = busImm;
                expDout = w.imm;
              end
            end
          endcase
        end
        opStr:
        begin
          c.busSrc = busRegOut;
          c.srcA = w.operand1;
          if (w.opvar == 2'd0)
          begin
            c.ramWrite = 1'b1;
            expAddrs.ram = w.imm;
          end
          else if (w.opvar == 2'd2)
          begin
            c.gpuWrite = 1'b1;
            expAddrs.gpu = w.imm;
          end
        end
        opSpt:
        begin
          c.srcA = w.operand1;
          if (w.opvar[0])
          begin
            c.gpuWrite = 1'b1;
            expAddrs.gpu = p.h;
          end
          else
          begin
            c.ramWrite = 1'b1;
            expAddrs.ram = p.f;
          end
          c.busSrc = w.opvar[1] ? busImm : busRegOut;
          if (w.opvar[1])
            expDout = w.imm;
        end
        opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot, opLsl, opLsr:
        begin
          c.srcA = w.operand1;
          c.dest = (w.opcode == opCmp) ? 3'd0 : w.results;
          c.aluFunc = expectedAlu(w.opcode);
          case (w.opvar)
            2'd0:
            begin
              c.busSrc = busRam;
              c.aluReadBus = 1'b1;
              expAddrs.ram = w.imm;
            end
            2'd1:
              c.srcB = w.operand2;
            2'd2:
            begin
              c.busSrc = busGpu;
              c.aluReadBus = 1'b1;
              expAddrs.gpu = w.imm;
            end
            default:
            begin
              c.busSrc = busImm;
              c.aluReadBus = 1'b1;
              expDout = w.imm;
            end
          endcase
        end
        opJmp: flow = 1;
        opJsr: flow = 2;
        opRts: flow = 3;
        opJoc, opJsc, opRsc:
        begin
          // mask is operand2 over operand1
          if ((condMask_t'({w.operand2, w.operand1}) & st) != 6'd0)
          begin
            condTaken++;
            if (w.opcode == opJoc)
              flow = 1;
            else if (w.opcode == opJsc)
              flow = 2;
            else
              flow = 3;
          end
          else
            condSkipped++;
        end
        default:
        begin
          // NOP, DIV, MOD and unassigned codes
        end
      endcase

      case (flow)
        1: expPc = w.imm;
        2:
        begin
          stackModel[sp] = expPc + 16'd1;
          sp = (sp + 1) % `STACK_DEPTH;
          expPc = w.imm;
        end
        3:
        begin
          sp = (sp + `STACK_DEPTH - 1) % `STACK_DEPTH;
          expPc = stackModel[sp];
        end
        default: expPc = expPc + 16'd1;
      endcase
    end
    expCtrl = c;
  endfunction

  task automatic abortRun();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic checkCtrl(string name, dpCtrl_t exp, dpCtrl_t act);
    if (act !== exp)
    begin
      $display("ERR %s dpCtrl: expected %h, actual %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic checkAddrs(string name, memAddrs_t exp, memAddrs_t act);
    if (act !== exp)
    begin
      $display("ERR %s memAddrs: expected %h, actual %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic checkWord(string name, string what, word_t exp, word_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
      abortRun();
    end
  endtask

  function automatic instr_t randomWord(opcode_e op, logic [1:0] v);
    instr_t w;
    w = instr_t'($urandom);
    w.opcode = op;
    w.opvar = v;
    return w;
  endfunction

  function automatic ptrRegs_t randomPtrs();
    ptrRegs_t p;
    p.f = word_t'($urandom);
    p.g = word_t'($urandom);
    p.h = word_t'($urandom);
    return p;
  endfunction

  task automatic applyCycle(logic rst, instr_t w, aluStatus_t st, ptrRegs_t p, string name);
    @(negedge CLK);
    rstN = rst;
    controlWord = w;
    aluStatus = st;
    ptrRegs = p;
    testName = name;
    modelStep(rst, w, st, p);
  endtask

  // outputs settle at the rising edge and are sampled a quarter period later
  always @(posedge CLK)
  begin
    #10;
    cycles = cycles + 1;
    if (cycles > CycleLimit)
    begin
      $display("timeout: no end of test after %0d cycles", CycleLimit);
      abortRun();
    end
    else
    begin
      checkCtrl(testName, expCtrl, dpCtrl);
      checkAddrs(testName, expAddrs, memAddrs);
      checkWord(testName, "dout", expDout, dout);
      checkWord(testName, "progRomAdd", expPc, progRomAdd);
    end
  end

  initial
  begin
    opcode_e ldst [4];
    opcode_e aluOps [10];
    logic [4:0] idleCodes [14];
    opcode_e condOp;
    int k;
    ldst = '{opLdr, opStr, opLpt, opSpt};
    aluOps = '{opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot, opLsl, opLsr};
    idleCodes = '{5'h00, 5'h09, 5'h0A, 5'h11, 5'h12, 5'h13, 5'h1A,
                  5'h1B, 5'h1C, 5'h1D, 5'h1E, 5'h1F, 5'h09, 5'h0A};
    void'($urandom(33490));
    rstN = 1'b0;
    controlWord = '0;
    aluStatus = '0;
    ptrRegs = '0;
    cycles = 0;
    condTaken = 0;
    condSkipped = 0;
    sp = 0;
    testName = "reset";

    repeat (3)
      applyCycle(1'b0, instr_t'($urandom), aluStatus_t'($urandom), randomPtrs(), "reset");

    for (int rep = 0; rep < 8; rep++)
      foreach (ldst[i])
        for (int v = 0; v < 4; v++)
          applyCycle(1'b1, randomWord(ldst[i], 2'(v)), aluStatus_t'($urandom),
                     randomPtrs(), "loadStore");

    for (int rep = 0; rep < 4; rep++)
      foreach (aluOps[i])
        for (int v = 0; v < 4; v++)
          applyCycle(1'b1, randomWord(aluOps[i], 2'(v)), aluStatus_t'($urandom),
                     randomPtrs(), "aluGroup");

    // nesting to full depth also fills every stack entry
    repeat (4)
      applyCycle(1'b1, randomWord(opJmp, 2'($urandom)), aluStatus_t'($urandom),
                 randomPtrs(), "jump");
    repeat (`STACK_DEPTH)
      applyCycle(1'b1, randomWord(opJsr, 2'($urandom)), aluStatus_t'($urandom),
                 randomPtrs(), "nestedCall");
    repeat (`STACK_DEPTH)
      applyCycle(1'b1, randomWord(opRts, 2'($urandom)), aluStatus_t'($urandom),
                 randomPtrs(), "nestedReturn");

    repeat (200)
    begin
      k = $urandom % 3;
      case (k)
        0: condOp = opJoc;
        1: condOp = opJsc;
        default: condOp = opRsc;
      endcase
      applyCycle(1'b1, randomWord(condOp, 2'($urandom)), aluStatus_t'($urandom),
                 randomPtrs(), "conditional");
    end

    for (int rep = 0; rep < 2; rep++)
      foreach (idleCodes[i])
        for (int v = 0; v < 4; v++)
          applyCycle(1'b1, randomWord(opcode_e'(idleCodes[i]), 2'(v)),
                     aluStatus_t'($urandom), randomPtrs(), "idleOpcode");

    repeat (300)
      applyCycle(1'b1, instr_t'($urandom), aluStatus_t'($urandom), randomPtrs(),
                 "randomMix");

    @(negedge CLK);
    if (condTaken == 0 || condSkipped == 0)
    begin
      $display("conditional branches missed an outcome: taken %0d, skipped %0d",
               condTaken, condSkipped);
      abortRun();
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule
